/* verilog/ctn_shell_pkg.sv */
// Shared definitions for the CTN chip shell
// Bus widths, address map, pad placement and enum types
`default_nettype none

package ctn_shell_pkg;

  // Bus
  localparam int unsigned CtnAddrWidth = 32;
  localparam int unsigned CtnDataWidth = 32;

  typedef logic [CtnAddrWidth-1:0] ctn_addr_t;
  typedef logic [CtnDataWidth-1:0] ctn_word_t;

  // GPIO pins and logical pads
  localparam int unsigned NumPins = 32;
  localparam int unsigned NumPads = 19;

  typedef logic [NumPins-1:0] pin_vec_t;
  typedef logic [NumPads-1:0] pad_vec_t;

  localparam int PadGpioFirst    = 0;
  localparam int PadGpioLast     = 13;
  localparam int PadSwStrapFirst = 14;
  localparam int PadSwStrapLast  = 16;
  localparam int PadTapStrap0    = 17;
  localparam int PadTapStrap1    = 18;

  // Pin positions of the straps
  localparam int PinSwStrapFirst = 22;
  localparam int PinTapStrap0    = 30;
  localparam int PinTapStrap1    = 27;

  // Address map
  localparam ctn_addr_t   SramBaseAddr     = 32'h4000_0000;
  localparam int unsigned DefaultSramDepth = 256;
  localparam ctn_addr_t   PadBaseAddr      = 32'h4010_0000;
  localparam int unsigned PadRegionBytes   = 32;

  typedef enum logic [1:0] {
    CtnSelSram = 2'd0,
    CtnSelPad  = 2'd1,
    CtnSelNone = 2'd2
  } ctn_sel_e;

  // Pad register word offsets
  typedef enum logic [2:0] {
    PadRegOut     = 3'd0,
    PadRegOe      = 3'd1,
    PadRegPullEn  = 3'd2,
    PadRegPullSel = 3'd3,
    PadRegIn      = 3'd4
  } pad_reg_e;

  // Fake power-on sequence
  localparam int unsigned PorSupplyMax    = 15;
  localparam int unsigned PorStableCycles = 4;

endpackage

`default_nettype wire

/* verilog/por_sequencer.sv */
// Fake power-on sequencer
// Drives a glitching supply pattern and derives power-good from it
`timescale 1ns/100ps
`default_nettype none

module por_sequencer
  import ctn_shell_pkg::*;
(
  input  logic clk_aon,
  input  logic rst_n_i,
  output logic por_done_o
);

  logic [$clog2(PorSupplyMax+1)-1:0]    supply_cnt;
  logic [$clog2(PorStableCycles+1)-1:0] stable_cnt;
  logic                                 vcc_supp;

  // Count up and stick at the top
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      supply_cnt <= '0;
    end else if (supply_cnt < PorSupplyMax) begin
      supply_cnt <= supply_cnt + 1'b1;
    end
  end

  // Low, high, low, then high for good
  assign vcc_supp = (supply_cnt < 4)  ? 1'b0 :
                    (supply_cnt < 8)  ? 1'b1 :
                    (supply_cnt < 12) ? 1'b0 : 1'b1;

  // Supply must stay high for a while before power-good
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stable_cnt <= '0;
    end else if (!vcc_supp) begin
      stable_cnt <= '0;
    end else if (stable_cnt < PorStableCycles) begin
      stable_cnt <= stable_cnt + 1'b1;
    end
  end

  assign por_done_o = (stable_cnt >= PorStableCycles);

endmodule

`default_nettype wire

/* verilog/ctn_addr_decode.sv */
// CTN bus decoder
// Steers requests to SRAM or pad registers and returns in-order responses
`timescale 1ns/100ps
`default_nettype none

module ctn_addr_decode
  import ctn_shell_pkg::*;
#(
  parameter int unsigned SramDepth = DefaultSramDepth
) (
  input  logic      clk_aon,
  input  logic      rst_n_i,
  input  logic      por_done_i,
  input  logic      ctn_req_i,
  input  logic      ctn_we_i,
  input  ctn_addr_t ctn_addr_i,
  input  ctn_word_t ctn_wdata_i,
  input  ctn_word_t sram_rdata_i,
  input  ctn_word_t pad_rdata_i,
  output logic      sram_req_o,
  output logic      pad_req_o,
  output logic      dev_we_o,
  output ctn_addr_t dev_word_addr_o,
  output ctn_word_t dev_wdata_o,
  output logic      ctn_rsp_valid_o,
  output logic      ctn_err_o,
  output ctn_word_t ctn_rdata_o
);

  localparam int unsigned SramRegionBytes = 4 * SramDepth;
  localparam ctn_addr_t   SramMask        = ~ctn_addr_t'(SramRegionBytes - 1);
  localparam ctn_addr_t   PadMask         = ~ctn_addr_t'(PadRegionBytes - 1);

  ctn_sel_e  req_sel;
  ctn_addr_t req_offset;
  logic      s1_valid;
  ctn_sel_e  s1_sel;
  logic      s2_valid;
  ctn_sel_e  s2_sel;
  ctn_word_t rsp_rdata_d;

  // Base and size match, anything else errors
  always_comb begin
    req_sel    = CtnSelNone;
    req_offset = '0;
    if ((ctn_addr_i & SramMask) == SramBaseAddr) begin
      req_sel    = CtnSelSram;
      req_offset = ctn_addr_i & ~SramMask;
    end else if ((ctn_addr_i & PadMask) == PadBaseAddr) begin
      req_sel    = CtnSelPad;
      req_offset = ctn_addr_i & ~PadMask;
    end
  end

  ////////////////////////////////////////
  // Stage 1 request to the devices
  ////////////////////////////////////////

  // Requests before power-good are dropped
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid <= 1'b0;
      s1_sel   <= CtnSelNone;
    end else begin
      s1_valid <= ctn_req_i & por_done_i;
      s1_sel   <= req_sel;
    end
  end

  always_ff @(posedge clk_aon) begin
    if (ctn_req_i) begin
      dev_we_o        <= ctn_we_i;
      dev_word_addr_o <= {2'b00, req_offset[CtnAddrWidth-1:2]};
      dev_wdata_o     <= ctn_wdata_i;
    end
  end

  assign sram_req_o = s1_valid && (s1_sel == CtnSelSram);
  assign pad_req_o  = s1_valid && (s1_sel == CtnSelPad);

  ////////////////////////////////////////
  // Stage 2 and response
  ////////////////////////////////////////

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s2_valid <= 1'b0;
      s2_sel   <= CtnSelNone;
    end else begin
      s2_valid <= s1_valid;
      s2_sel   <= s1_sel;
    end
  end

  // Device read data is valid while stage 2 holds the request
  always_comb begin
    rsp_rdata_d = '0;
    if (s2_valid) begin
      case (s2_sel)
        CtnSelSram: rsp_rdata_d = sram_rdata_i;
        CtnSelPad:  rsp_rdata_d = pad_rdata_i;
        default:    rsp_rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctn_rsp_valid_o <= 1'b0;
      ctn_err_o       <= 1'b0;
    end else begin
      ctn_rsp_valid_o <= s2_valid;
      ctn_err_o       <= s2_valid && (s2_sel == CtnSelNone);
    end
  end

  always_ff @(posedge clk_aon) begin
    ctn_rdata_o <= rsp_rdata_d;
  end

endmodule

`default_nettype wire

/* verilog/ctn_sram.sv */
// Single-port CTN SRAM
// Full-word writes and registered reads
`timescale 1ns/100ps
`default_nettype none

module ctn_sram
  import ctn_shell_pkg::*;
#(
  parameter int unsigned SramDepth = DefaultSramDepth
) (
  input  logic      clk_aon,
  input  logic      rst_n_i,
  input  logic      req_i,
  input  logic      we_i,
  input  ctn_addr_t word_addr_i,
  input  ctn_word_t wdata_i,
  output ctn_word_t rdata_o
);

  localparam int unsigned IdxWidth = $clog2(SramDepth);

  ctn_word_t             mem [SramDepth];
  logic [IdxWidth-1:0]   mem_idx;

  // Decoder already limits the offset to the region
  assign mem_idx = word_addr_i[IdxWidth-1:0];

  always_ff @(posedge clk_aon) begin
    if (req_i && we_i) begin
      mem[mem_idx] <= wdata_i;
    end
  end

  // Read port, writes return zero
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_o <= '0;
    end else if (req_i) begin
      if (we_i) begin
        rdata_o <= '0;
      end else begin
        rdata_o <= mem[mem_idx];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/pad_ctrl_regs.sv */
// Pad control registers
// Output, enable and pull settings per pad plus input readback
`timescale 1ns/100ps
`default_nettype none

module pad_ctrl_regs
  import ctn_shell_pkg::*;
(
  input  logic      clk_aon,
  input  logic      rst_n_i,
  input  logic      req_i,
  input  logic      we_i,
  input  ctn_addr_t word_addr_i,
  input  ctn_word_t wdata_i,
  input  pad_vec_t  pad_in_i,
  output ctn_word_t rdata_o,
  output pad_vec_t  pad_out_o,
  output pad_vec_t  pad_oe_o,
  output pad_vec_t  pad_pull_en_o,
  output pad_vec_t  pad_pull_sel_o
);

  pad_reg_e reg_sel;

  assign reg_sel = pad_reg_e'(word_addr_i[2:0]);

  ////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////

  // PadRegIn and offsets 5 to 7 are read-only
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pad_out_o      <= '0;
      pad_oe_o       <= '0;
      pad_pull_en_o  <= '0;
      pad_pull_sel_o <= '0;
    end else if (req_i && we_i) begin
      case (reg_sel)
        PadRegOut:     pad_out_o      <= wdata_i[NumPads-1:0];
        PadRegOe:      pad_oe_o       <= wdata_i[NumPads-1:0];
        PadRegPullEn:  pad_pull_en_o  <= wdata_i[NumPads-1:0];
        PadRegPullSel: pad_pull_sel_o <= wdata_i[NumPads-1:0];
        default:       ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Register reads
  ////////////////////////////////////////

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= '0;
      if (!we_i) begin
        case (reg_sel)
          PadRegOut:     rdata_o <= ctn_word_t'(pad_out_o);
          PadRegOe:      rdata_o <= ctn_word_t'(pad_oe_o);
          PadRegPullEn:  rdata_o <= ctn_word_t'(pad_pull_en_o);
          PadRegPullSel: rdata_o <= ctn_word_t'(pad_pull_sel_o);
          PadRegIn:      rdata_o <= ctn_word_t'(pad_in_i);
          default:       rdata_o <= '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/pad_map.sv */
// Pad to pin mapping
// Places logical pads on GPIO pins and synchronizes their inputs
`timescale 1ns/100ps
`default_nettype none

module pad_map
  import ctn_shell_pkg::*;
(
  input  logic     clk_aon,
  input  logic     rst_n_i,
  input  pin_vec_t gpio_p2d_i,
  input  pad_vec_t pad_out_i,
  input  pad_vec_t pad_oe_i,
  input  pad_vec_t pad_pull_en_i,
  input  pad_vec_t pad_pull_sel_i,
  output pad_vec_t pad_in_o,
  output pin_vec_t gpio_d2p_o,
  output pin_vec_t gpio_en_d2p_o,
  output pin_vec_t gpio_pull_en_o,
  output pin_vec_t gpio_pull_select_o
);

  pad_vec_t pad_in_async;
  pad_vec_t pad_in_meta;

  // Unused pins stay at zero
  function automatic pin_vec_t pads_to_pins(pad_vec_t pads);
    pin_vec_t pins;
    pins = '0;
    for (int i = PadGpioFirst; i <= PadGpioLast; i++) begin
      pins[i - PadGpioFirst] = pads[i];
    end
    for (int i = PadSwStrapFirst; i <= PadSwStrapLast; i++) begin
      pins[PinSwStrapFirst + i - PadSwStrapFirst] = pads[i];
    end
    pins[PinTapStrap0] = pads[PadTapStrap0];
    pins[PinTapStrap1] = pads[PadTapStrap1];
    return pins;
  endfunction

  function automatic pad_vec_t pins_to_pads(pin_vec_t pins);
    pad_vec_t pads;
    pads = '0;
    for (int i = PadGpioFirst; i <= PadGpioLast; i++) begin
      pads[i] = pins[i - PadGpioFirst];
    end
    for (int i = PadSwStrapFirst; i <= PadSwStrapLast; i++) begin
      pads[i] = pins[PinSwStrapFirst + i - PadSwStrapFirst];
    end
    pads[PadTapStrap0] = pins[PinTapStrap0];
    pads[PadTapStrap1] = pins[PinTapStrap1];
    return pads;
  endfunction

  assign gpio_d2p_o         = pads_to_pins(pad_out_i);
  assign gpio_en_d2p_o      = pads_to_pins(pad_oe_i);
  assign gpio_pull_en_o     = pads_to_pins(pad_pull_en_i);
  assign gpio_pull_select_o = pads_to_pins(pad_pull_sel_i);

  assign pad_in_async = pins_to_pads(gpio_p2d_i);

  // Two-flop synchronizer on the pad inputs
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pad_in_meta <= '0;
      pad_in_o    <= '0;
    end else begin
      pad_in_meta <= pad_in_async;
      pad_in_o    <= pad_in_meta;
    end
  end

endmodule

`default_nettype wire

/* verilog/ctn_chip_shell.sv */
// CTN chip shell top level
// Connects power-on, bus decode, SRAM, pad registers and pin mapping
`timescale 1ns/100ps
`default_nettype none

module ctn_chip_shell
  import ctn_shell_pkg::*;
#(
  parameter int unsigned SramDepth = DefaultSramDepth
) (
  input  logic      clk_aon,
  input  logic      rst_n_i,
  // CTN bus
  input  logic      ctn_req_i,
  input  logic      ctn_we_i,
  input  ctn_addr_t ctn_addr_i,
  input  ctn_word_t ctn_wdata_i,
  output logic      ctn_rsp_valid_o,
  output logic      ctn_err_o,
  output ctn_word_t ctn_rdata_o,
  // GPIO pins
  input  pin_vec_t  gpio_p2d_i,
  output pin_vec_t  gpio_d2p_o,
  output pin_vec_t  gpio_en_d2p_o,
  output pin_vec_t  gpio_pull_en_o,
  output pin_vec_t  gpio_pull_select_o,
  output logic      por_done_o
);

  logic      sram_req;
  logic      pad_req;
  logic      dev_we;
  ctn_addr_t dev_word_addr;
  ctn_word_t dev_wdata;
  ctn_word_t sram_rdata;
  ctn_word_t pad_rdata;
  pad_vec_t  pad_in;
  pad_vec_t  pad_out;
  pad_vec_t  pad_oe;
  pad_vec_t  pad_pull_en;
  pad_vec_t  pad_pull_sel;

  ////////////////////////////////////////
  // Power-on and bus
  ////////////////////////////////////////

  por_sequencer u_por_sequencer (
    .clk_aon    (clk_aon),
    .rst_n_i    (rst_n_i),
    .por_done_o (por_done_o)
  );

  ctn_addr_decode #(
    .SramDepth (SramDepth)
  ) u_ctn_addr_decode (
    .clk_aon         (clk_aon),
    .rst_n_i         (rst_n_i),
    .por_done_i      (por_done_o),
    .ctn_req_i       (ctn_req_i),
    .ctn_we_i        (ctn_we_i),
    .ctn_addr_i      (ctn_addr_i),
    .ctn_wdata_i     (ctn_wdata_i),
    .sram_rdata_i    (sram_rdata),
    .pad_rdata_i     (pad_rdata),
    .sram_req_o      (sram_req),
    .pad_req_o       (pad_req),
    .dev_we_o        (dev_we),
    .dev_word_addr_o (dev_word_addr),
    .dev_wdata_o     (dev_wdata),
    .ctn_rsp_valid_o (ctn_rsp_valid_o),
    .ctn_err_o       (ctn_err_o),
    .ctn_rdata_o     (ctn_rdata_o)
  );

  ////////////////////////////////////////
  // Devices and pads
  ////////////////////////////////////////

  ctn_sram #(
    .SramDepth (SramDepth)
  ) u_ctn_sram (
    .clk_aon     (clk_aon),
    .rst_n_i     (rst_n_i),
    .req_i       (sram_req),
    .we_i        (dev_we),
    .word_addr_i (dev_word_addr),
    .wdata_i     (dev_wdata),
    .rdata_o     (sram_rdata)
  );

  pad_ctrl_regs u_pad_ctrl_regs (
    .clk_aon        (clk_aon),
    .rst_n_i        (rst_n_i),
    .req_i          (pad_req),
    .we_i           (dev_we),
    .word_addr_i    (dev_word_addr),
    .wdata_i        (dev_wdata),
    .pad_in_i       (pad_in),
    .rdata_o        (pad_rdata),
    .pad_out_o      (pad_out),
    .pad_oe_o       (pad_oe),
    .pad_pull_en_o  (pad_pull_en),
    .pad_pull_sel_o (pad_pull_sel)
  );

  pad_map u_pad_map (
    .clk_aon            (clk_aon),
    .rst_n_i            (rst_n_i),
    .gpio_p2d_i         (gpio_p2d_i),
    .pad_out_i          (pad_out),
    .pad_oe_i           (pad_oe),
    .pad_pull_en_i      (pad_pull_en),
    .pad_pull_sel_i     (pad_pull_sel),
    .pad_in_o           (pad_in),
    .gpio_d2p_o         (gpio_d2p_o),
    .gpio_en_d2p_o      (gpio_en_d2p_o),
    .gpio_pull_en_o     (gpio_pull_en_o),
    .gpio_pull_select_o (gpio_pull_select_o)
  );

endmodule

`default_nettype wire

/* tests/ctn_chip_shell_assertions.sv */
// Protocol assertions for the CTN chip shell
// Response latency, error data and unused pin enables
`timescale 1ns/100ps
`default_nettype none

module ctn_chip_shell_assertions
  import ctn_shell_pkg::*;
(
  input wire logic      clk_aon,
  input wire logic      rst_n_i,
  input wire logic      ctn_req_i,
  input wire logic      por_done_o,
  input wire logic      ctn_rsp_valid_o,
  input wire logic      ctn_err_o,
  input wire ctn_word_t ctn_rdata_o,
  input wire pin_vec_t  gpio_en_d2p_o
);

  // Pins 14 to 21, 25, 26, 28, 29 and 31
  localparam pin_vec_t UnusedPins = 32'hB63F_C000;

  // Valid is set by edge N+2, so it is first sampled high at N+3
  req_gets_rsp: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    ctn_req_i && por_done_o |-> ##3 ctn_rsp_valid_o)
    else $error("request without a response");

  rsp_has_req: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    ctn_rsp_valid_o |-> $past(ctn_req_i && por_done_o, 3))
    else $error("response without a request");

  err_zero_data: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    ctn_rsp_valid_o && ctn_err_o |-> ctn_rdata_o == '0)
    else $error("error response with nonzero data");

  unused_oe_low: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    (gpio_en_d2p_o & UnusedPins) == '0)
    else $error("output enable on an unused pin");

endmodule

bind ctn_chip_shell ctn_chip_shell_assertions u_assertions (
  .clk_aon         (clk_aon),
  .rst_n_i         (rst_n_i),
  .ctn_req_i       (ctn_req_i),
  .por_done_o      (por_done_o),
  .ctn_rsp_valid_o (ctn_rsp_valid_o),
  .ctn_err_o       (ctn_err_o),
  .ctn_rdata_o     (ctn_rdata_o),
  .gpio_en_d2p_o   (gpio_en_d2p_o)
);

`default_nettype wire

/* tests/ctn_chip_shell_tb.sv */
// Testbench for the CTN chip shell
// Power-on, bus decode, SRAM, pad registers and pin mapping
`timescale 1ns/100ps
`default_nettype none

module ctn_chip_shell_tb
  import ctn_shell_pkg::*;
;

  localparam int          RspTimeout = 10;
  localparam int          PorTimeout = 40;
  localparam int          PipeOps    = 24;
  localparam int unsigned RandSeed   = 32'hf5e0_cf40;
  localparam ctn_addr_t   SramEnd    = SramBaseAddr + 4 * DefaultSramDepth;

  // Pin of each logical pad, GPIOs first then straps
  localparam int PadPin [NumPads] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13,
                                      22, 23, 24, 30, 27};

  typedef enum {OpWrite, OpRead, OpPins, OpInput} test_op_e;

  typedef struct {
    string     name;
    test_op_e  op;
    ctn_addr_t addr;
    ctn_word_t wdata;
    logic      exp_err;
  } test_step_t;

  logic      clk_aon;
  logic      rst_n_i;
  logic      ctn_req_i;
  logic      ctn_we_i;
  ctn_addr_t ctn_addr_i;
  ctn_word_t ctn_wdata_i;
  logic      ctn_rsp_valid_o;
  logic      ctn_err_o;
  ctn_word_t ctn_rdata_o;
  pin_vec_t  gpio_p2d_i;
  pin_vec_t  gpio_d2p_o;
  pin_vec_t  gpio_en_d2p_o;
  pin_vec_t  gpio_pull_en_o;
  pin_vec_t  gpio_pull_select_o;
  logic      por_done_o;

  test_step_t steps[$];
  ctn_word_t  ref_mem [int unsigned];
  pad_vec_t   ref_pad [4];
  ctn_word_t  pipe_exp_q[$];
  int         pipe_rsp_cnt;

  ctn_chip_shell ctn_chip_shell_inst (.*);

  initial begin
    clk_aon = 1'b0;
    forever #10 clk_aon = ~clk_aon;
  end

  ////////////////////////////////////////
  // Reporting and checks
  ////////////////////////////////////////

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic timeout_error(input string what);
    $display("Timeout: %s", what);
    abort_run();
  endtask

  task automatic check_word(input string name, input ctn_word_t exp, input ctn_word_t act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_pins(input string name, input pin_vec_t exp, input pin_vec_t act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Mismatch %s: expected err %b, actual err %b", name, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic pin_vec_t pins_from_pads(pad_vec_t pads);
    pin_vec_t pins;
    pins = '0;
    for (int p = 0; p < NumPads; p++) begin
      pins[PadPin[p]] = pads[p];
    end
    return pins;
  endfunction

  function automatic pad_vec_t pads_from_pins(pin_vec_t pins);
    pad_vec_t pads;
    for (int p = 0; p < NumPads; p++) begin
      pads[p] = pins[PadPin[p]];
    end
    return pads;
  endfunction

  function automatic logic in_sram(ctn_addr_t addr);
    return (addr >= SramBaseAddr) && (addr < SramEnd);
  endfunction

  function automatic logic in_pad(ctn_addr_t addr);
    return (addr >= PadBaseAddr) && (addr < PadBaseAddr + PadRegionBytes);
  endfunction

  task automatic model_write(input ctn_addr_t addr, input ctn_word_t wdata);
    int unsigned off;
    if (in_sram(addr)) begin
      ref_mem[(addr - SramBaseAddr) >> 2] = wdata;
    end else if (in_pad(addr)) begin
      off = (addr - PadBaseAddr) >> 2;
      // Input register and spare offsets are read-only
      if (off < 4) ref_pad[off] = wdata[NumPads-1:0];
    end
  endtask

  function automatic ctn_word_t model_read(ctn_addr_t addr);
    int unsigned off;
    if (in_sram(addr) && ref_mem.exists((addr - SramBaseAddr) >> 2)) begin
      return ref_mem[(addr - SramBaseAddr) >> 2];
    end
    if (in_pad(addr)) begin
      off = (addr - PadBaseAddr) >> 2;
      if (off < 4) return ctn_word_t'(ref_pad[off]);
    end
    return '0;
  endfunction

  ////////////////////////////////////////
  // Bus access
  ////////////////////////////////////////

  task automatic bus_access(input string name, input logic we, input ctn_addr_t addr,
                            input ctn_word_t wdata, output ctn_word_t rdata,
                            output logic err);
    int waited;
    @(negedge clk_aon);
    ctn_req_i   = 1'b1;
    ctn_we_i    = we;
    ctn_addr_i  = addr;
    ctn_wdata_i = wdata;
    @(negedge clk_aon);
    ctn_req_i = 1'b0;
    waited    = 0;
    while (!ctn_rsp_valid_o) begin
      if (waited == RspTimeout) timeout_error({"no response for ", name});
      @(negedge clk_aon);
      waited++;
    end
    rdata = ctn_rdata_o;
    err   = ctn_err_o;
  endtask

  task automatic run_step(input test_step_t s);
    ctn_word_t rdata;
    logic      err;
    pin_vec_t  pins;
    case (s.op)
      OpWrite: begin
        bus_access(s.name, 1'b1, s.addr, s.wdata, rdata, err);
        check_err(s.name, s.exp_err, err);
        check_word(s.name, '0, rdata);
        if (!s.exp_err) model_write(s.addr, s.wdata);
      end
      OpRead: begin
        bus_access(s.name, 1'b0, s.addr, '0, rdata, err);
        check_err(s.name, s.exp_err, err);
        check_word(s.name, s.exp_err ? '0 : model_read(s.addr), rdata);
      end
      OpPins: begin
        @(negedge clk_aon);
        check_pins({s.name, "_out"}, pins_from_pads(ref_pad[0]), gpio_d2p_o);
        check_pins({s.name, "_oe"}, pins_from_pads(ref_pad[1]), gpio_en_d2p_o);
        check_pins({s.name, "_pull_en"}, pins_from_pads(ref_pad[2]), gpio_pull_en_o);
        check_pins({s.name, "_pull_sel"}, pins_from_pads(ref_pad[3]), gpio_pull_select_o);
      end
      default: begin
        pins = $urandom;
        @(negedge clk_aon);
        gpio_p2d_i = pins;
        // Two synchronizer stages plus margin
        repeat (3) @(negedge clk_aon);
        bus_access(s.name, 1'b0, s.addr, '0, rdata, err);
        check_err(s.name, 1'b0, err);
        check_word(s.name, ctn_word_t'(pads_from_pins(pins)), rdata);
      end
    endcase
  endtask

  task automatic add_step(input string name, input test_op_e op, input ctn_addr_t addr,
                          input ctn_word_t wdata, input logic exp_err);
    test_step_t s;
    s.name    = name;
    s.op      = op;
    s.addr    = addr;
    s.wdata   = wdata;
    s.exp_err = exp_err;
    steps.push_back(s);
  endtask

  ////////////////////////////////////////
  // Pipelined SRAM traffic
  ////////////////////////////////////////

  task automatic collect_response();
    ctn_word_t exp;
    string     name;
    if (ctn_rsp_valid_o) begin
      if (pipe_exp_q.size() == 0) begin
        $display("Response arrived with no request outstanding");
        abort_run();
      end
      exp  = pipe_exp_q.pop_front();
      name = $sformatf("pipe_%0d", pipe_rsp_cnt);
      pipe_rsp_cnt++;
      check_err(name, 1'b0, ctn_err_o);
      check_word(name, exp, ctn_rdata_o);
    end
  endtask

  task automatic run_pipelined();
    ctn_addr_t addr;
    int        waited;
    logic      do_read;
    for (int i = 0; i < PipeOps; i++) begin
      @(negedge clk_aon);
      collect_response();
      // Spread over a few words so reads hit earlier writes
      addr    = SramBaseAddr + 4 * (32 * $urandom_range(7) + 1);
      do_read = ref_mem.exists((addr - SramBaseAddr) >> 2) && ($urandom_range(1) == 1);
      ctn_req_i   = 1'b1;
      ctn_we_i    = !do_read;
      ctn_addr_i  = addr;
      ctn_wdata_i = $urandom;
      if (do_read) begin
        pipe_exp_q.push_back(model_read(addr));
      end else begin
        model_write(addr, ctn_wdata_i);
        pipe_exp_q.push_back('0);
      end
    end
    @(negedge clk_aon);
    collect_response();
    ctn_req_i = 1'b0;
    waited    = 0;
    while (pipe_exp_q.size() != 0) begin
      if (waited == RspTimeout) timeout_error("pipelined responses did not all return");
      @(negedge clk_aon);
      waited++;
      collect_response();
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int phase;
    int cycles;
    void'($urandom(RandSeed));
    rst_n_i      = 1'b0;
    ctn_req_i    = 1'b0;
    ctn_we_i     = 1'b0;
    ctn_addr_i   = '0;
    ctn_wdata_i  = '0;
    gpio_p2d_i   = '0;
    pipe_rsp_cnt = 0;
    foreach (ref_pad[i]) ref_pad[i] = '0;

    repeat (2) @(posedge clk_aon);
    @(negedge clk_aon);
    rst_n_i = 1'b1;

    // Early request must be dropped
    if (por_done_o) begin
      $display("Power-good was already high right after reset");
      abort_run();
    end
    ctn_req_i  = 1'b1;
    ctn_addr_i = SramBaseAddr;
    @(negedge clk_aon);
    ctn_req_i = 1'b0;

    // Rise, glitch low, rise again
    phase  = 0;
    cycles = 0;
    while (phase < 3) begin
      if (cycles == PorTimeout) timeout_error("power-on sequence did not complete");
      @(negedge clk_aon);
      cycles++;
      if (ctn_rsp_valid_o) begin
        $display("A request issued before power-good got a response");
        abort_run();
      end
      if ((phase == 1) ^ por_done_o) phase++;
    end
    repeat (8) begin
      @(negedge clk_aon);
      if (!por_done_o) begin
        $display("Power-good dropped after the sequence settled");
        abort_run();
      end
    end

    add_step("sram_wr_first", OpWrite, SramBaseAddr,           32'hA5A5_0001, 1'b0);
    add_step("sram_wr_mid",   OpWrite, SramBaseAddr + 'h200,   32'h1234_5678, 1'b0);
    add_step("sram_wr_last",  OpWrite, SramEnd - 4,            32'hDEAD_BEEF, 1'b0);
    add_step("sram_rd_first", OpRead,  SramBaseAddr,           '0,            1'b0);
    add_step("sram_rd_mid",   OpRead,  SramBaseAddr + 'h200,   '0,            1'b0);
    add_step("sram_rd_last",  OpRead,  SramEnd - 4,            '0,            1'b0);
    add_step("err_below",     OpWrite, SramBaseAddr - 4,       32'hFFFF_FFFF, 1'b1);
    add_step("err_past_sram", OpWrite, SramEnd,                32'h0BAD_0BAD, 1'b1);
    add_step("err_past_pad",  OpWrite, PadBaseAddr + 32,       32'h0BAD_0BAD, 1'b1);
    add_step("err_far",       OpRead,  32'h8000_0000,          '0,            1'b1);
    add_step("sram_rd_after", OpRead,  SramBaseAddr,           '0,            1'b0);
    add_step("pad_wr_out",    OpWrite, PadBaseAddr,            32'hFFFF_FFFF, 1'b0);
    add_step("pad_wr_oe",     OpWrite, PadBaseAddr + 4,        32'h0005_A5C3, 1'b0);
    add_step("pad_wr_pull",   OpWrite, PadBaseAddr + 8,        32'hFFFF_FFFF, 1'b0);
    add_step("pad_wr_sel",    OpWrite, PadBaseAddr + 12,       32'h0002_AAAA, 1'b0);
    add_step("pad_wr_in",     OpWrite, PadBaseAddr + 16,       32'h7FFF_FFFF, 1'b0);
    add_step("pad_wr_spare",  OpWrite, PadBaseAddr + 20,       32'h7FFF_FFFF, 1'b0);
    add_step("pad_pins",      OpPins,  '0,                     '0,            1'b0);
    add_step("pad_rd_out",    OpRead,  PadBaseAddr,            '0,            1'b0);
    add_step("pad_rd_oe",     OpRead,  PadBaseAddr + 4,        '0,            1'b0);
    add_step("pad_rd_pull",   OpRead,  PadBaseAddr + 8,        '0,            1'b0);
    add_step("pad_rd_sel",    OpRead,  PadBaseAddr + 12,       '0,            1'b0);
    add_step("pad_rd_spare",  OpRead,  PadBaseAddr + 20,       '0,            1'b0);
    add_step("pad_wr_out2",   OpWrite, PadBaseAddr,            32'h0004_3C0F, 1'b0);
    add_step("pad_pins2",     OpPins,  '0,                     '0,            1'b0);
    add_step("pad_in_0",      OpInput, PadBaseAddr + 16,       '0,            1'b0);
    add_step("pad_in_1",      OpInput, PadBaseAddr + 16,       '0,            1'b0);
    add_step("pad_in_2",      OpInput, PadBaseAddr + 16,       '0,            1'b0);

    foreach (steps[i]) run_step(steps[i]);
    run_pipelined();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* ctn_chip_shell.f */
verilog/ctn_shell_pkg.sv
verilog/por_sequencer.sv
verilog/ctn_addr_decode.sv
verilog/ctn_sram.sv
verilog/pad_ctrl_regs.sv
verilog/pad_map.sv
verilog/ctn_chip_shell.sv
tests/ctn_chip_shell_assertions.sv
tests/ctn_chip_shell_tb.sv

/* Bender.yml */
package:
  name: ctn_chip_shell

sources:
  - files:
      - verilog/ctn_shell_pkg.sv
      - verilog/por_sequencer.sv
      - verilog/ctn_addr_decode.sv
      - verilog/ctn_sram.sv
      - verilog/pad_ctrl_regs.sv
      - verilog/pad_map.sv
      - verilog/ctn_chip_shell.sv
  - target: test
    files:
      - tests/ctn_chip_shell_assertions.sv
      - tests/ctn_chip_shell_tb.sv
